// File: cache_sys.f
hdl/cache_pkg.sv
hdl/cache_ram.sv
hdl/cache_lookup.sv
hdl/cache_fill_fsm.sv
hdl/cache_cfg_regs.sv
hdl/cache_sys.sv
verif/cache_sys_assertions.sv
verif/cache_sys_tb.sv

// File: verif/cache_sys_tb.sv
`timescale 1ns/1ps

module cache_sys_tb
  import cache_pkg::*;
();

  localparam int    clk_period      = 8;        // Clock period in ns.
  localparam int    reset_cycles    = 10;       // Cycles with rst_n held low.
  localparam int    num_tests       = 5;        // Directed tests in the run.
  localparam int    cycles_per_test = 200;      // Watchdog budget for one test.
  localparam word_t data_key        = 16'hA5A5; // Memory word is its address XOR this key.

  logic                  clk;       // DUT clock.
  logic                  rst_n;     // DUT reset.
  cpu_req_t              cpu_req;   // Processor request.
  cpu_rsp_t              cpu_rsp;   // Processor response.
  logic                  stall;     // Processor stall.
  mem_req_t              mem_req;   // Memory request from the fill machine.
  mem_rsp_t              mem_rsp;   // Memory model answer.
  cfg_wr_t               cfg_wr;    // Configuration write.
  logic [cfg_addr_w-1:0] cfg_addr;  // Configuration read address.
  word_t                 cfg_rdata; // Configuration read data.
  logic [31:0]           lfsr_q;    // Random source for memory delays.
  word_t                 exp_hits;  // Hits expected from the reads issued so far.
  word_t                 exp_misses; // Misses expected from the reads issued so far.

  cache_sys i_cache_sys (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk; // Free running clock.
  end

  ////////////////////////////////////////////////////////////
  // Helpers: random source, failure exit and compares.
  ////////////////////////////////////////////////////////////
  // Taps 32, 22, 2 and 1; one shift per bit handed out.
  function automatic int unsigned random_bits(input int count);
    logic        feedback;
    int unsigned value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      feedback = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q   = {lfsr_q[30:0], feedback};
      value    = (value << 1) | feedback;
    end
    return value;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic check_word(input string test_name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected 0x%04h, actual 0x%04h", test_name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_count(input string test_name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %0d, actual %0d", test_name, expected, actual);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus tasks, all entered and left on a falling edge.
  ////////////////////////////////////////////////////////////
  task automatic cpu_read(input string test_name, input logic [addr_w-1:0] addr,
                          input bit expect_miss);
    bit saw_stall;
    int cycles;
    saw_stall = 1'b0;
    cycles    = 0;
    cpu_req   = '{read: 1'b1, addr: addr}; // Held until the response shows up.
    do begin
      @(negedge clk);
      cycles++;
      if (stall) begin
        saw_stall = 1'b1;                  // A fill is under way.
      end
    end while (!cpu_rsp.valid);
    cpu_req = '{read: 1'b0, addr: '0};
    if (saw_stall && !expect_miss) begin
      report_failure($sformatf("%s: read of 0x%04h stalled although it should hit.",
                               test_name, addr));
    end
    if (!saw_stall && expect_miss) begin
      report_failure($sformatf("%s: read of 0x%04h did not stall although it should miss.",
                               test_name, addr));
    end
    if (!expect_miss && (cycles != 1)) begin
      report_failure($sformatf("%s: hit on 0x%04h answered after %0d cycles, not one.",
                               test_name, addr, cycles));
    end
    check_word(test_name, addr ^ data_key, cpu_rsp.data);
    exp_hits++;                            // The held request ends as one hit.
    if (expect_miss) begin
      exp_misses++;
    end
  endtask

  task automatic read_counter(input logic [cfg_addr_w-1:0] addr, output word_t value);
    cfg_addr = addr;
    @(negedge clk);
    value = cfg_rdata;                     // Combinational path settled a cycle ago.
  endtask

  task automatic verify_counters(input string test_name);
    word_t value;
    read_counter(cfg_hits_addr, value);
    check_count({test_name, " hits"}, exp_hits, value);
    read_counter(cfg_misses_addr, value);
    check_count({test_name, " misses"}, exp_misses, value);
  endtask

  task automatic write_control(input word_t value);
    cfg_wr = '{wr: 1'b1, addr: cfg_ctrl_addr, data: value};
    @(negedge clk);
    cfg_wr = '0;                           // Strobe lasts one cycle.
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests.
  ////////////////////////////////////////////////////////////
  task automatic reset_state_is_idle();
    if (stall || cpu_rsp.valid || mem_req.read) begin
      report_failure("reset_state: stall, response or memory read is high after reset.");
    end
    verify_counters("reset_state");
  endtask

  task automatic cold_read_fills_line();
    cpu_read("cold_read", 16'h0124, 1'b1);
    verify_counters("cold_read");          // One miss and one hit.
  endtask

  task automatic same_line_hits();
    for (int i = 0; i < words_per_line; i++) begin
      cpu_read("same_line", 16'h0120 + 16'(2 * i), 1'b0);
    end
    verify_counters("same_line");
  endtask

  task automatic conflict_refills_set();
    cpu_read("conflict", 16'h3A2A, 1'b1);  // Set 2 again, another tag.
    cpu_read("conflict", 16'h0124, 1'b1);  // First line was evicted.
    verify_counters("conflict");
  endtask

  task automatic flush_clears_lines();
    cpu_read("flush", 16'h0124, 1'b0);
    write_control(16'h0001);               // Flush every line.
    cpu_read("flush", 16'h0124, 1'b1);
    verify_counters("flush");
    write_control(16'h0002);               // Zero both counters.
    exp_hits   = '0;
    exp_misses = '0;
    verify_counters("counter_clear");
  endtask

  ////////////////////////////////////////////////////////////
  // Memory model, answers each requested word after 1 to 4 cycles.
  ////////////////////////////////////////////////////////////
  initial begin : memory_model
    int unsigned       delay;
    logic [addr_w-1:0] addr;
    mem_rsp = '0;
    forever begin
      @(negedge clk);
      mem_rsp = '0;                        // Each word is a one cycle pulse.
      if (mem_req.read) begin
        addr  = mem_req.addr;
        delay = random_bits(2) + 1;
        repeat (delay) @(negedge clk);
        mem_rsp = '{valid: 1'b1, data: addr ^ data_key};
      end
    end
  end

  initial begin : watchdog
    repeat (reset_cycles + num_tests * cycles_per_test) @(posedge clk);
    $display("Watchdog expired before the tests finished.");
    abort_run();
  end

  initial begin : main_sequence
    lfsr_q     = 32'h7993;
    rst_n      = 1'b0;
    cpu_req    = '0;
    cfg_wr     = '0;
    cfg_addr   = '0;
    exp_hits   = '0;
    exp_misses = '0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    reset_state_is_idle();
    cold_read_fills_line();
    same_line_hits();
    conflict_refills_set();
    flush_clears_lines();
    if (i_cache_sys.i_cache_fill_fsm.i_cache_sys_assertions.error_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Bound assertions on the fill machine failed.");
      abort_run();
    end
  end

endmodule

// File: verif/cache_sys_assertions.sv
`timescale 1ns/1ps

module cache_sys_assertions
  import cache_pkg::*;
(
  input logic     clk,       // Clock of the fill machine.
  input logic     rst_n,     // Asynchronous active low reset.
  input mem_req_t mem_req,   // Word request towards memory.
  input mem_rsp_t mem_rsp,   // Word return from memory.
  input logic     busy,      // Stall towards the processor.
  input logic     data_we,   // Data store write enable.
  input logic     line_done  // End of a line fill.
);

  int unsigned error_count; // Failed assertions, read by the testbench at the end.

  initial begin
    error_count = 0;
  end

  ////////////////////////////////////////////////////////////
  // Fill machine timing rules.
  ////////////////////////////////////////////////////////////
  // Memory is only asked for words while the processor is held, and the
  // first request comes one cycle after the stall rose.
  read_needs_busy: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req.read |-> busy && $past(busy))
    else begin
      error_count++;
      $error("mem_req.read is high without busy held since the previous cycle");
    end

  // The tag write lasts one cycle and follows the eighth stored word.
  line_done_single: assert property (@(posedge clk) disable iff (!rst_n)
    line_done |-> $past(data_we) && !$past(line_done))
    else begin
      error_count++;
      $error("line_done is longer than one cycle or not right after the last word");
    end

  // Every word written into the data store came from memory during a fill.
  write_needs_word: assert property (@(posedge clk) disable iff (!rst_n)
    data_we |-> mem_rsp.valid && $past(busy))
    else begin
      error_count++;
      $error("data_we is high without a memory word inside a fill");
    end

endmodule

bind cache_fill_fsm cache_sys_assertions i_cache_sys_assertions (.*);

// File: hdl/cache_sys.sv
`timescale 1ns/1ps

module cache_sys
  import cache_pkg::*;
(
  input  logic                  clk,       // Clock.
  input  logic                  rst_n,     // Asynchronous active low reset.
  input  cpu_req_t              cpu_req,   // Processor read request.
  output cpu_rsp_t              cpu_rsp,   // Processor read response.
  output logic                  stall,     // Processor must hold its request.
  output mem_req_t              mem_req,   // Line fill request to memory.
  input  mem_rsp_t              mem_rsp,   // Memory word return.
  input  cfg_wr_t               cfg_wr,    // Configuration write.
  input  logic [cfg_addr_w-1:0] cfg_addr,  // Configuration read address.
  output word_t                 cfg_rdata  // Configuration read data.
);

  logic [index_w-1:0]          req_index;   // Set of the current request.
  logic [offset_w-1:0]         req_offset;  // Word of the current request.
  tag_t                        rd_tag;      // Stored tag of the set.
  word_t                       rd_word;     // Stored word at set and offset.
  logic                        miss;        // Lookup miss level.
  logic                        hit_pulse;   // Hit event for the counters.
  logic                        miss_pulse;  // Miss event for the counters.
  logic                        flush;       // Invalidate all lines.
  logic                        data_we;     // Fill word write enable.
  logic [offset_w-1:0]         fill_offset; // Fill word slot.
  word_t                       fill_word;   // Fill word value.
  logic                        line_done;   // Fill finished, write the tag.

  // The request is held during a fill, so its fields also address the fill writes.
  assign req_index  = cpu_req.addr[index_lsb +: index_w];
  assign req_offset = cpu_req.addr[offset_lsb +: offset_w];

  cache_lookup i_cache_lookup (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu_req    (cpu_req),
    .stall      (stall),
    .rd_tag     (rd_tag),
    .rd_word    (rd_word),
    .line_done  (line_done),
    .flush      (flush),
    .cpu_rsp    (cpu_rsp),
    .miss       (miss),
    .hit_pulse  (hit_pulse),
    .miss_pulse (miss_pulse)
  );

  // Busy already covers the miss cycle, so it is the processor stall.
  cache_fill_fsm i_cache_fill_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .miss        (miss),
    .miss_addr   (cpu_req.addr),
    .mem_rsp     (mem_rsp),
    .mem_req     (mem_req),
    .busy        (stall),
    .data_we     (data_we),
    .fill_offset (fill_offset),
    .fill_word   (fill_word),
    .line_done   (line_done)
  );

  cache_ram #(.entry_t(tag_t)) i_tag_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (line_done),
    .waddr (req_index),
    .wdata (cpu_req.addr[tag_lsb +: tag_w]),
    .raddr (req_index),
    .rdata (rd_tag)
  );

  cache_ram #(.entry_t(word_t)) i_data_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (data_we),
    .waddr ({req_index, fill_offset}),
    .wdata (fill_word),
    .raddr ({req_index, req_offset}),
    .rdata (rd_word)
  );

  cache_cfg_regs i_cache_cfg_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_wr     (cfg_wr),
    .cfg_addr   (cfg_addr),
    .hit_pulse  (hit_pulse),
    .miss_pulse (miss_pulse),
    .cfg_rdata  (cfg_rdata),
    .flush      (flush)
  );

endmodule

// File: hdl/cache_cfg_regs.sv
`timescale 1ns/1ps

module cache_cfg_regs
  import cache_pkg::*;
(
  input  logic                  clk,        // Clock.
  input  logic                  rst_n,      // Asynchronous active low reset.
  input  cfg_wr_t               cfg_wr,     // Register write port.
  input  logic [cfg_addr_w-1:0] cfg_addr,   // Register read address.
  input  logic                  hit_pulse,  // One accepted hit.
  input  logic                  miss_pulse, // One new miss.
  output word_t                 cfg_rdata,  // Addressed register, combinational.
  output logic                  flush       // Invalidate all lines.
);

  logic  ctrl_wr;  // Write to the control register.
  logic  clear;    // Counter clear command.
  word_t hits_q;   // Saturating hit counter.
  word_t misses_q; // Saturating miss counter.

  ////////////////////////////////////////////////////////////
  // Control register decode.
  ////////////////////////////////////////////////////////////
  assign ctrl_wr = cfg_wr.wr && (cfg_wr.addr == cfg_ctrl_addr); // Write hits the control word.
  assign flush   = ctrl_wr && cfg_wr.data[0];                   // Acts on the write edge.
  assign clear   = ctrl_wr && cfg_wr.data[1];                   // Zeroes both counters.

  ////////////////////////////////////////////////////////////
  // Hit and miss counters, held at all ones when full.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hits_q <= '0;
    end else if (clear) begin
      hits_q <= '0;                       // Clear wins over a hit in the same cycle.
    end else if (hit_pulse && (hits_q != '1)) begin
      hits_q <= hits_q + word_t'(1);      // Count until saturation.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      misses_q <= '0;
    end else if (clear) begin
      misses_q <= '0;
    end else if (miss_pulse && (misses_q != '1)) begin
      misses_q <= misses_q + word_t'(1);  // Each miss counts once, at fill start.
    end
  end

  // Read mux, the control word and the spare address return zero.
  always_comb begin
    case (cfg_addr)
      cfg_hits_addr:   cfg_rdata = hits_q;
      cfg_misses_addr: cfg_rdata = misses_q;
      default:         cfg_rdata = '0;
    endcase
  end

endmodule

// File: hdl/cache_fill_fsm.sv
`timescale 1ns/1ps

module cache_fill_fsm
  import cache_pkg::*;
(
  input  logic                clk,         // Clock.
  input  logic                rst_n,       // Asynchronous active low reset.
  input  logic                miss,        // Lookup reports an absent line.
  input  logic [addr_w-1:0]   miss_addr,   // Address that missed.
  input  mem_rsp_t            mem_rsp,     // Words returned by memory.
  output mem_req_t            mem_req,     // Word request to memory.
  output logic                busy,        // Stall towards the processor.
  output logic                data_we,     // Data store write enable.
  output logic [offset_w-1:0] fill_offset, // Word slot being written.
  output word_t               fill_word,   // Word being written.
  output logic                line_done    // Tag write and valid set.
);

  typedef enum logic {
    idle_s, // Waiting for a miss.
    wait_s  // Collecting the eight words of a line.
  } state_t;

  state_t            state_q;    // Current state.
  state_t            state_d;    // Next state.
  logic [3:0]        count_q;    // Words received so far, 0 to 8.
  logic [addr_w-1:0] addr_q;     // Address of the next word wanted.
  logic              start;      // Load the counter and the line base.
  logic              take;       // Accept one memory word.
  logic              all_words;  // Eighth word already stored.

  assign all_words = (count_q == 4'(words_per_line)); // Counter reached eight.

  ////////////////////////////////////////////////////////////
  // State transition and output decode.
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d   = state_q;   // Hold the state by default.
    start     = 1'b0;      // No new fill by default.
    take      = 1'b0;      // No word taken by default.
    busy      = 1'b0;      // Processor runs by default.
    line_done = 1'b0;      // No tag write by default.
    case (state_q)
      idle_s: begin
        busy  = miss;                       // Stall rises in the miss cycle itself.
        start = miss;                       // Capture the line base address.
        if (miss) begin
          state_d = wait_s;
        end
      end
      wait_s: begin
        if (all_words) begin
          line_done = 1'b1;                 // Tag write, valid set, stall falls.
          state_d   = idle_s;
        end else begin
          busy = 1'b1;                      // Keep the processor waiting on memory.
          take = mem_rsp.valid;             // Store each returned word.
        end
      end
      default: begin
        state_d = idle_s;                   // Recover from an unused encoding.
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= idle_s;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Word counter and memory address register.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      addr_q  <= '0;
    end else if (start) begin
      count_q <= '0;                                  // New line starts at word zero.
      addr_q  <= {miss_addr[addr_w-1:index_lsb], 4'h0}; // Line base, aligned to 16 bytes.
    end else if (take) begin
      count_q <= count_q + 4'd1;                      // One more word stored.
      addr_q  <= addr_q + addr_w'(2);                 // Step to the next word.
    end
  end

  // Read stays high from the cycle after the miss until the eighth word arrives.
  assign mem_req = '{read: (state_q == wait_s) && !all_words, addr: addr_q};

  assign data_we     = take;                   // A pulse after the eighth is dropped.
  assign fill_offset = count_q[offset_w-1:0];  // Words arrive in address order.
  assign fill_word   = mem_rsp.data;           // Memory word goes straight to the store.

endmodule

// File: hdl/cache_lookup.sv
`timescale 1ns/1ps

module cache_lookup
  import cache_pkg::*;
(
  input  logic     clk,        // Clock.
  input  logic     rst_n,      // Asynchronous active low reset.
  input  cpu_req_t cpu_req,    // Processor read request.
  input  logic     stall,      // High while the fill machine holds the processor.
  input  tag_t     rd_tag,     // Tag stored for the requested set.
  input  word_t    rd_word,    // Word stored at the requested set and offset.
  input  logic     line_done,  // Last cycle of a line fill.
  input  logic     flush,      // Invalidate every line.
  output cpu_rsp_t cpu_rsp,    // Registered read response.
  output logic     miss,       // Request pending and line absent.
  output logic     hit_pulse,  // One cycle per accepted hit.
  output logic     miss_pulse  // One cycle per new miss.
);

  logic [num_sets-1:0] valid_q;     // One valid bit per set.
  logic [index_w-1:0]  req_index;   // Set selected by the request.
  tag_t                req_tag;     // Tag carried by the request.
  logic                tag_hit;     // Stored line matches the request.
  logic                hit;         // Request can be served this cycle.
  logic                accept;      // Hit that the processor sees as taken.
  logic                miss_seen_q; // Miss already reported to the counters.
  logic                rsp_valid_q; // Response valid flop.
  word_t               rsp_data_q;  // Response data flop.

  assign req_index = cpu_req.addr[index_lsb +: index_w]; // Set index is address bits 6:4.
  assign req_tag   = cpu_req.addr[tag_lsb +: tag_w];     // Tag is address bits 15:7.

  ////////////////////////////////////////////////////////////
  // Hit and miss decision.
  ////////////////////////////////////////////////////////////
  assign tag_hit = valid_q[req_index] && (rd_tag == req_tag); // Line present and tags agree.
  // On line_done all eight words are already in the data store and the held
  // request is the one being filled, so it is served while the tag is written.
  assign hit        = cpu_req.read && (tag_hit || line_done);
  assign miss       = cpu_req.read && !hit;  // Drives the fill machine.
  assign accept     = hit && !stall;         // Stall is low on any hit.
  assign hit_pulse  = accept;                // Retried access counts as a single hit.
  assign miss_pulse = miss && !miss_seen_q;  // Only the first cycle of a miss counts.

  // Valid bits are set when a fill ends and all cleared by a flush.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;                    // Cache starts empty.
    end else if (flush) begin
      valid_q <= '0;                    // Flush drops every line on its write edge.
    end else if (line_done) begin
      valid_q[req_index] <= 1'b1;       // Filled line becomes usable.
    end
  end

  // Remember that the pending miss has already been counted.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      miss_seen_q <= 1'b0;
    end else begin
      miss_seen_q <= miss;              // Clears once the request hits.
    end
  end

  ////////////////////////////////////////////////////////////
  // Registered response, one cycle after acceptance.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= accept;            // Single cycle pulse per accepted read.
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_data_q <= rd_word;            // Capture the word with its valid pulse.
    end
  end

  assign cpu_rsp = '{valid: rsp_valid_q, data: rsp_data_q};

endmodule

// File: hdl/cache_ram.sv
`timescale 1ns/1ps

module cache_ram
  import cache_pkg::*;
#(
  parameter type entry_t = word_t,
  // Tags need one entry per set, data words one per word of every line.
  localparam int aw = ($bits(entry_t) == tag_w) ? index_w : index_w + offset_w
) (
  input  logic          clk,   // Clock.
  input  logic          rst_n, // Asynchronous active low reset.
  input  logic          we,    // Write enable.
  input  logic [aw-1:0] waddr, // Entry being written.
  input  entry_t        wdata, // Value being written.
  input  logic [aw-1:0] raddr, // Entry being read.
  output entry_t        rdata  // Read value, no latency.
);

  localparam int depth = 1 << aw; // Number of entries in the array.

  entry_t mem_q [depth]; // Flop based storage array.

  ////////////////////////////////////////////////////////////
  // Single synchronous write port.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < depth; i++) begin
        mem_q[i] <= '0;       // Clear every entry so reads are never unknown.
      end
    end else if (we) begin
      mem_q[waddr] <= wdata; // Store the entry on the write edge.
    end
  end

  // The read is a plain mux, so a word written on one edge is visible right after it.
  assign rdata = mem_q[raddr];

endmodule

// File: hdl/cache_pkg.sv
package cache_pkg;

  ////////////////////////////////////////////////////////////
  // Geometry of the direct-mapped instruction cache.
  ////////////////////////////////////////////////////////////
  localparam int addr_w         = 16;                   // Byte address width.
  localparam int word_w         = 16;                   // Data word width.
  localparam int words_per_line = 8;                    // Words held by one cache line.
  localparam int num_sets       = 8;                    // Number of sets, one line each.
  localparam int offset_w       = 3;                    // Word select within a line.
  localparam int index_w        = 3;                    // Set index width.
  localparam int tag_w          = 9;                    // Tag width.
  localparam int offset_lsb     = 1;                    // Bit 0 is the byte within a word.
  localparam int index_lsb      = offset_lsb + offset_w; // Set index sits at bits 6:4.
  localparam int tag_lsb        = index_lsb + index_w;   // Tag sits at bits 15:7.

  ////////////////////////////////////////////////////////////
  // Configuration register map.
  ////////////////////////////////////////////////////////////
  localparam int cfg_addr_w = 2;                               // Register address width.
  localparam logic [cfg_addr_w-1:0] cfg_ctrl_addr   = 2'd0;    // Bit 0 flushes, bit 1 clears.
  localparam logic [cfg_addr_w-1:0] cfg_hits_addr   = 2'd1;    // Hit counter.
  localparam logic [cfg_addr_w-1:0] cfg_misses_addr = 2'd2;    // Miss counter.

  typedef logic [word_w-1:0] word_t; // One data word.
  typedef logic [tag_w-1:0]  tag_t;  // One stored tag.

  typedef struct packed {
    logic              read; // Level, held by the processor while stalled.
    logic [addr_w-1:0] addr; // Byte address of the wanted word.
  } cpu_req_t;

  typedef struct packed {
    logic  valid; // One cycle pulse with the returned word.
    word_t data;  // Word read from the cache.
  } cpu_rsp_t;

  typedef struct packed {
    logic              read; // Level, high for the whole line fill.
    logic [addr_w-1:0] addr; // Address of the next word wanted.
  } mem_req_t;

  typedef struct packed {
    logic  valid; // At most one pulse per cycle, in address order.
    word_t data;  // Word returned by memory.
  } mem_rsp_t;

  typedef struct packed {
    logic                  wr;   // Single cycle write strobe.
    logic [cfg_addr_w-1:0] addr; // Register being written.
    word_t                 data; // Write data.
  } cfg_wr_t;

endpackage
